//--- rtl/fwd_ext_pkg.sv
package fwd_ext_pkg;

	// ------------------------------------------------------------------
	// widths and limits
	// ------------------------------------------------------------------
	localparam int WORD_W     = 64;  // one bi-interval word
	localparam int POS_W      = 7;   // query position and min_intv
	localparam int PTR_W      = 7;   // current-match queue pointer
	localparam int READ_NUM_W = 10;
	localparam int ADDR_W     = 32;  // dram line address
	localparam int OCC_DEPTH  = 12;  // latency of the occurrence unit

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [POS_W-1:0]  pos_t;
	typedef logic [PTR_W-1:0]  ptr_t;

	localparam pos_t LEN = 7'd101;  // query length, position limit

	typedef enum logic [5:0] {
		F_INIT  = 6'h00,  // first round, no occurrence result yet
		F_RUN   = 6'h01,
		F_BREAK = 6'h02,
		BCK_INI = 6'h04,  // handed over to the backward phase
		BUBBLE  = 6'h30   // empty slot
	} status_e;

	typedef enum logic [2:0] {
		BASE_A = 3'd0,
		BASE_C = 3'd1,
		BASE_G = 3'd2,
		BASE_T = 3'd3,
		BASE_N = 3'd4    // ambiguous base
	} base_e;

	// ------------------------------------------------------------------
	// item and bus structs
	// ------------------------------------------------------------------
	typedef struct packed {
		word_t x0;
		word_t x1;
		word_t x2;    // interval size
		word_t info;  // query position the interval ends at
	} bi_interval_t;

	typedef struct packed {
		status_e                 status;
		base_e                   query;
		ptr_t                    ptr_curr;
		logic [READ_NUM_W-1:0]   read_num;
		bi_interval_t            ik;
		pos_t                    forward_i;
		pos_t                    min_intv;
	} fwd_item_t;

	typedef struct packed {
		word_t k;
		word_t l;
	} occ_req_t;

	typedef bi_interval_t [3:0] occ_result_t;  // index 0 is base A

	typedef struct packed {
		fwd_item_t    item;
		bi_interval_t chosen;
		logic         update_ik;
	} decided_item_t;

	typedef struct packed {
		fwd_item_t item;
		word_t     k;
		word_t     l;
		word_t     k_minus;
		word_t     l_minus;
	} update_item_t;

	typedef struct packed {
		logic                  we;
		logic [READ_NUM_W-1:0] read_num;
		ptr_t                  addr;
		bi_interval_t          data;
	} curr_write_t;

	typedef struct packed {
		logic                  valid;
		logic [31:0]           value;
		logic [READ_NUM_W-1:0] read_num;
	} ret_t;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr_k;
		logic [ADDR_W-1:0] addr_l;
	} mem_req_t;

	// the primary row is not stored in the bwt, positions past it shift by one
	function automatic word_t correct_pos(input word_t value, input word_t primary);
		return (value >= primary) ? value - word_t'(1) : value;
	endfunction

endpackage

//--- rtl/occ_position_stage.sv
`timescale 1ns/1ps

module occ_position_stage (
	input  logic                   Clk_32UI,
	input  logic                   reset_BWT_extend,
	input  logic                   stall_i,
	input  fwd_ext_pkg::fwd_item_t item_i,
	input  fwd_ext_pkg::word_t     primary_i,
	output fwd_ext_pkg::occ_req_t  occ_req_o,
	output fwd_ext_pkg::fwd_item_t item_o
);

	fwd_ext_pkg::word_t k_raw;
	fwd_ext_pkg::word_t l_raw;
	logic               at_limit;

	assign k_raw = item_i.ik.x1 - fwd_ext_pkg::word_t'(1);
	assign l_raw = k_raw + item_i.ik.x2;

	// position limit reached, the item cannot extend any further
	assign at_limit = (item_i.status == fwd_ext_pkg::F_RUN) &&
	                  (item_i.forward_i >= fwd_ext_pkg::LEN);

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_o.status <= fwd_ext_pkg::BUBBLE;
		end else if (!stall_i) begin
			item_o <= item_i;
			if (at_limit) begin
				item_o.status <= fwd_ext_pkg::F_BREAK;
			end
			occ_req_o.k <= fwd_ext_pkg::correct_pos(k_raw, primary_i);  // to occurrence unit
			occ_req_o.l <= fwd_ext_pkg::correct_pos(l_raw, primary_i);
		end
	end

endmodule

//--- rtl/item_delay_line.sv
`timescale 1ns/1ps

module item_delay_line (
	input  logic                   Clk_32UI,
	input  logic                   reset_BWT_extend,
	input  logic                   stall_i,
	input  fwd_ext_pkg::fwd_item_t item_i,
	output fwd_ext_pkg::fwd_item_t item_o
);

	fwd_ext_pkg::fwd_item_t stage_q [fwd_ext_pkg::OCC_DEPTH];

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			for (int i = 0; i < fwd_ext_pkg::OCC_DEPTH; i++) begin
				stage_q[i].status <= fwd_ext_pkg::BUBBLE;
			end
		end else if (!stall_i) begin
			stage_q[0] <= item_i;
			for (int i = 1; i < fwd_ext_pkg::OCC_DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];  // shift along with the occurrence unit
			end
		end
	end

	assign item_o = stage_q[fwd_ext_pkg::OCC_DEPTH-1];

endmodule

//--- rtl/extend_decision.sv
`timescale 1ns/1ps

module extend_decision (
	input  logic                       Clk_32UI,
	input  logic                       reset_BWT_extend,
	input  logic                       stall_i,
	input  fwd_ext_pkg::fwd_item_t     item_i,
	input  fwd_ext_pkg::occ_result_t   ok_i,
	output fwd_ext_pkg::curr_write_t   curr_wr_o,
	output fwd_ext_pkg::ret_t          ret_o,
	output fwd_ext_pkg::decided_item_t item_o
);

	logic [1:0]                comp_idx;
	fwd_ext_pkg::bi_interval_t chosen;
	fwd_ext_pkg::word_t        min_intv_ext;
	fwd_ext_pkg::status_e      next_status;
	logic                      queue_we;
	logic                      ret_en;
	logic                      update_ik;

	// forward extension looks up the complement base
	assign comp_idx     = 2'd3 - item_i.query[1:0];
	assign chosen       = ok_i[comp_idx];
	assign min_intv_ext = fwd_ext_pkg::word_t'(item_i.min_intv);

	// ------------------------------------------------------------------
	// status transition
	// ------------------------------------------------------------------
	always_comb begin
		next_status = item_i.status;
		queue_we    = 1'b0;
		ret_en      = 1'b0;
		update_ik   = 1'b0;
		case (item_i.status)
			fwd_ext_pkg::F_RUN: begin
				if (item_i.query <= fwd_ext_pkg::BASE_T) begin
					queue_we = (chosen.x2 != item_i.ik.x2);  // size changed, keep old match
					if (chosen.x2 < min_intv_ext) begin
						next_status = fwd_ext_pkg::F_BREAK;
					end else begin
						update_ik = 1'b1;
					end
				end else begin
					queue_we    = 1'b1;  // ambiguous base ends the extension
					next_status = fwd_ext_pkg::F_BREAK;
				end
			end
			fwd_ext_pkg::F_BREAK: begin
				queue_we    = (item_i.forward_i == fwd_ext_pkg::LEN);  // reached query end
				ret_en      = 1'b1;
				next_status = fwd_ext_pkg::BCK_INI;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_o.item.status <= fwd_ext_pkg::BUBBLE;
			curr_wr_o.we       <= 1'b0;
			ret_o.valid        <= 1'b0;
		end else if (!stall_i) begin
			item_o.item          <= item_i;
			item_o.item.status   <= next_status;
			item_o.item.ptr_curr <= item_i.ptr_curr + fwd_ext_pkg::ptr_t'(queue_we);
			item_o.chosen        <= chosen;
			item_o.update_ik     <= update_ik;

			curr_wr_o.we       <= queue_we;
			curr_wr_o.read_num <= queue_we ? item_i.read_num : '0;
			curr_wr_o.addr     <= queue_we ? item_i.ptr_curr : '0;
			curr_wr_o.data     <= queue_we ? item_i.ik : '0;

			ret_o.valid    <= ret_en;  // one-cycle strobe
			ret_o.value    <= ret_en ? item_i.ik.info[31:0] : '0;
			ret_o.read_num <= ret_en ? item_i.read_num : '0;
		end
	end

endmodule

//--- rtl/interval_update.sv
`timescale 1ns/1ps

module interval_update (
	input  logic                       Clk_32UI,
	input  logic                       reset_BWT_extend,
	input  logic                       stall_i,
	input  fwd_ext_pkg::decided_item_t item_i,
	output fwd_ext_pkg::update_item_t  item_o
);

	logic                      adopt;
	fwd_ext_pkg::bi_interval_t ik_next;
	fwd_ext_pkg::pos_t         fwd_next;
	fwd_ext_pkg::word_t        k_next;
	fwd_ext_pkg::word_t        l_next;

	assign adopt = (item_i.item.status == fwd_ext_pkg::F_RUN) && item_i.update_ik;

	always_comb begin
		ik_next  = item_i.item.ik;
		fwd_next = item_i.item.forward_i;
		if (adopt) begin
			ik_next.x0   = item_i.chosen.x0;
			ik_next.x1   = item_i.chosen.x1;
			ik_next.x2   = item_i.chosen.x2;
			ik_next.info = fwd_ext_pkg::word_t'(item_i.item.forward_i) +
			               fwd_ext_pkg::word_t'(1);  // i + 1
			fwd_next     = item_i.item.forward_i + fwd_ext_pkg::pos_t'(1);
		end
	end

	// positions for the next round, primary correction picks one later
	assign k_next = ik_next.x1 - fwd_ext_pkg::word_t'(1);
	assign l_next = k_next + ik_next.x2;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_o.item.status <= fwd_ext_pkg::BUBBLE;
		end else if (!stall_i) begin
			item_o.item           <= item_i.item;
			item_o.item.ik        <= ik_next;
			item_o.item.forward_i <= fwd_next;
			item_o.k              <= k_next;
			item_o.l              <= l_next;
			item_o.k_minus        <= k_next - fwd_ext_pkg::word_t'(1);
			item_o.l_minus        <= l_next - fwd_ext_pkg::word_t'(1);
		end
	end

endmodule

//--- rtl/dram_request_stage.sv
`timescale 1ns/1ps

module dram_request_stage (
	input  logic                      Clk_32UI,
	input  logic                      reset_BWT_extend,
	input  logic                      stall_i,
	input  fwd_ext_pkg::update_item_t item_i,
	input  fwd_ext_pkg::word_t        primary_i,
	output fwd_ext_pkg::mem_req_t     mem_req_o,
	output fwd_ext_pkg::fwd_item_t    item_o
);

	fwd_ext_pkg::word_t pos_k;
	fwd_ext_pkg::word_t pos_l;
	logic               issue;

	assign pos_k = (item_i.k >= primary_i) ? item_i.k_minus : item_i.k;
	assign pos_l = (item_i.l >= primary_i) ? item_i.l_minus : item_i.l;

	// break and backward items need no memory access
	assign issue = (item_i.item.status == fwd_ext_pkg::F_INIT) ||
	               (item_i.item.status == fwd_ext_pkg::F_RUN);

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			mem_req_o.valid <= 1'b0;
			item_o.status   <= fwd_ext_pkg::BUBBLE;
		end else if (!stall_i) begin
			mem_req_o.valid  <= issue;
			mem_req_o.addr_k <= issue ? {pos_k[34:7], 4'b0000} : '0;  // line address
			mem_req_o.addr_l <= issue ? {pos_l[34:7], 4'b0000} : '0;
			item_o <= item_i.item;
			if (item_i.item.status == fwd_ext_pkg::F_INIT) begin
				item_o.status <= fwd_ext_pkg::F_RUN;
			end
		end
	end

endmodule

//--- rtl/forward_extend_top.sv
`timescale 1ns/1ps

module forward_extend_top (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  fwd_ext_pkg::word_t       primary_i,
	input  fwd_ext_pkg::fwd_item_t   item_i,
	input  fwd_ext_pkg::occ_result_t ok_i,
	output fwd_ext_pkg::occ_req_t    occ_req_o,
	output fwd_ext_pkg::curr_write_t curr_wr_o,
	output fwd_ext_pkg::ret_t        ret_o,
	output fwd_ext_pkg::mem_req_t    mem_req_o,
	output fwd_ext_pkg::fwd_item_t   item_o
);

	fwd_ext_pkg::fwd_item_t     staged_item;
	fwd_ext_pkg::fwd_item_t     delayed_item;
	fwd_ext_pkg::decided_item_t decided_item;
	fwd_ext_pkg::update_item_t  updated_item;

	// ------------------------------------------------------------------
	// forward extension pipeline
	// ------------------------------------------------------------------
	occ_position_stage u_occ_position_stage (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (item_i),
		.primary_i        (primary_i),
		.occ_req_o        (occ_req_o),
		.item_o           (staged_item)
	);

	item_delay_line u_item_delay_line (  // waits for the occurrence results
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (staged_item),
		.item_o           (delayed_item)
	);

	extend_decision u_extend_decision (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (delayed_item),
		.ok_i             (ok_i),
		.curr_wr_o        (curr_wr_o),
		.ret_o            (ret_o),
		.item_o           (decided_item)
	);

	interval_update u_interval_update (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (decided_item),
		.item_o           (updated_item)
	);

	dram_request_stage u_dram_request_stage (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (updated_item),
		.primary_i        (primary_i),
		.mem_req_o        (mem_req_o),
		.item_o           (item_o)
	);

endmodule

//--- verification/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// taps 32 22 2 1, one call per bit taken
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

task automatic check_occ(input fwd_ext_pkg::occ_req_t got, input fwd_ext_pkg::occ_req_t exp);
	if (got !== exp) report_mismatch("occ_req_o", wide_t'(got), wide_t'(exp));
endtask

task automatic check_curr(input fwd_ext_pkg::curr_write_t got,
                          input fwd_ext_pkg::curr_write_t exp);
	if (got !== exp) report_mismatch("curr_wr_o", wide_t'(got), wide_t'(exp));
endtask

task automatic check_ret(input fwd_ext_pkg::ret_t got, input fwd_ext_pkg::ret_t exp);
	if (got !== exp) report_mismatch("ret_o", wide_t'(got), wide_t'(exp));
endtask

task automatic check_mem(input fwd_ext_pkg::mem_req_t got, input fwd_ext_pkg::mem_req_t exp);
	if (got !== exp) report_mismatch("mem_req_o", wide_t'(got), wide_t'(exp));
endtask

task automatic check_item(input fwd_ext_pkg::fwd_item_t got, input fwd_ext_pkg::fwd_item_t exp);
	if (got !== exp) report_mismatch("item_o", wide_t'(got), wide_t'(exp));
endtask

`endif

//--- verification/tb_forward_extend.sv
`timescale 1ns/1ps

module tb_forward_extend;

	localparam int NVEC    = 12;
	localparam int TIMEOUT = 2000;  // cycles per wait loop
	localparam int D       = fwd_ext_pkg::OCC_DEPTH;

	typedef logic [299:0] wide_t;

	typedef struct packed {
		fwd_ext_pkg::fwd_item_t   item;
		fwd_ext_pkg::occ_result_t ok;
		fwd_ext_pkg::occ_req_t    occ;
		fwd_ext_pkg::curr_write_t curr;
		fwd_ext_pkg::ret_t        ret;
		fwd_ext_pkg::mem_req_t    mem;
		fwd_ext_pkg::fwd_item_t   out;
	} vec_t;

	logic                     Clk_32UI = 1'b0;
	logic                     reset_BWT_extend;
	logic                     stall_i;
	fwd_ext_pkg::word_t       primary_i;
	fwd_ext_pkg::fwd_item_t   item_i;
	fwd_ext_pkg::occ_result_t ok_i;
	fwd_ext_pkg::occ_req_t    occ_req_o;
	fwd_ext_pkg::curr_write_t curr_wr_o;
	fwd_ext_pkg::ret_t        ret_o;
	fwd_ext_pkg::mem_req_t    mem_req_o;
	fwd_ext_pkg::fwd_item_t   item_o;

	vec_t                     vec_tbl [NVEC];
	fwd_ext_pkg::fwd_item_t   bubble;
	int                       occ_idx [D+1];  // occurrence unit model with one table index per slot
	int                       drv_idx;
	int                       idx;
	int                       wait_cnt;
	logic [31:0]              lfsr;
	logic                     run_en;
	logic                     check_en;

	fwd_ext_pkg::curr_write_t curr_q [$];
	fwd_ext_pkg::ret_t        ret_q [$];
	fwd_ext_pkg::mem_req_t    mem_q [$];
	fwd_ext_pkg::fwd_item_t   item_q [$];

	forward_extend_top u_forward_extend_top (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.primary_i        (primary_i),
		.item_i           (item_i),
		.ok_i             (ok_i),
		.occ_req_o        (occ_req_o),
		.curr_wr_o        (curr_wr_o),
		.ret_o            (ret_o),
		.mem_req_o        (mem_req_o),
		.item_o           (item_o)
	);

	always #10 Clk_32UI = ~Clk_32UI;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input wide_t got, input wide_t exp);
		$display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
		abort_run("output value mismatch");
	endtask

	`include "tb_checks.svh"

	// ------------------------------------------------------------------
	// vector table
	// ------------------------------------------------------------------
	function automatic fwd_ext_pkg::bi_interval_t iv(input fwd_ext_pkg::word_t x0,
		input fwd_ext_pkg::word_t x1, input fwd_ext_pkg::word_t x2, input fwd_ext_pkg::word_t info);
		return {x0, x1, x2, info};
	endfunction

	function automatic fwd_ext_pkg::fwd_item_t mk(input fwd_ext_pkg::status_e st,
		input fwd_ext_pkg::base_e q, input fwd_ext_pkg::ptr_t ptr, input fwd_ext_pkg::word_t x1,
		input fwd_ext_pkg::word_t x2, input fwd_ext_pkg::word_t info, input fwd_ext_pkg::pos_t fwd,
		input fwd_ext_pkg::pos_t minv);
		fwd_ext_pkg::fwd_item_t it;
		it           = '0;
		it.status    = st;
		it.query     = q;
		it.ptr_curr  = ptr;
		it.ik        = iv(64'h11, x1, x2, info);
		it.forward_i = fwd;
		it.min_intv  = minv;
		return it;
	endfunction

	// other bases carry junk so a wrong index shows up
	function automatic fwd_ext_pkg::occ_result_t ok_at(input int sel,
		input fwd_ext_pkg::bi_interval_t r);
		fwd_ext_pkg::occ_result_t ok;
		for (int b = 0; b < 4; b++) ok[b] = iv(64'hbad, 64'hbad0, 64'h1, 64'h0);
		ok[sel] = r;
		return ok;
	endfunction

	task automatic set_vec(input int i, input fwd_ext_pkg::fwd_item_t it,
		input fwd_ext_pkg::occ_result_t ok, input fwd_ext_pkg::word_t k, input fwd_ext_pkg::word_t l,
		input logic wr, input logic ret_on, input logic [31:0] ret_val, input logic mem_on,
		input logic [31:0] addr_k, input logic [31:0] addr_l, input fwd_ext_pkg::fwd_item_t out);
		vec_t v;
		v = '0;
		it.read_num  = 10'(i + 1);
		out.read_num = 10'(i + 1);
		v.item  = it;
		v.ok    = ok;
		v.occ   = {k, l};
		v.out   = out;
		if (wr) v.curr = {1'b1, it.read_num, it.ptr_curr, it.ik};  // old interval to queue
		if (ret_on) v.ret = {1'b1, ret_val, it.read_num};
		if (mem_on) v.mem = {1'b1, addr_k, addr_l};
		vec_tbl[i] = v;
	endtask

	task automatic build_table();
		fwd_ext_pkg::fwd_item_t it;
		fwd_ext_pkg::fwd_item_t out;
		it = mk(fwd_ext_pkg::F_INIT, fwd_ext_pkg::BASE_A, 0, 'h20000, 'h300, 0, 0, 10);
		out = it;
		out.status = fwd_ext_pkg::F_RUN;
		set_vec(0, it, '0, 'h1fffe, 'h202fe, 0, 0, 0, 1, 'h3ff0, 'h4050, out);
		it = mk(fwd_ext_pkg::F_RUN, fwd_ext_pkg::BASE_A, 5, 'h100, 'h40, 7, 20, 10);
		out = it;
		out.ptr_curr = 6;
		out.ik = iv(2, 'h18000, 'h20, 21);
		out.forward_i = 21;
		set_vec(1, it, ok_at(3, iv(2, 'h18000, 'h20, 0)), 'hff, 'h13f, 1, 0, 0, 1, 'h2ff0,
		        'h3000, out);
		it = mk(fwd_ext_pkg::F_RUN, fwd_ext_pkg::BASE_C, 0, 'h500, 'h30, 3, 30, 10);
		out = it;
		out.ik = iv(9, 'h600, 'h30, 31);
		out.forward_i = 31;
		set_vec(2, it, ok_at(2, iv(9, 'h600, 'h30, 0)), 'h4ff, 'h52f, 0, 0, 0, 1, 'hb0, 'hc0, out);
		it = mk(fwd_ext_pkg::F_RUN, fwd_ext_pkg::BASE_G, 2, 'h10000, 'h50, 9, 40, 10);
		out = it;
		out.status = fwd_ext_pkg::F_BREAK;
		out.ptr_curr = 3;
		set_vec(3, it, ok_at(1, iv(4, 'h700, 5, 0)), 'hffff, 'h1004e, 1, 0, 0, 0, 0, 0, out);
		it = mk(fwd_ext_pkg::F_RUN, fwd_ext_pkg::BASE_T, 7, 'h9000, 'h8, 1, 50, 8);
		out = it;
		out.ik = iv(3, 'h9100, 'h8, 51);
		out.forward_i = 51;
		set_vec(4, it, ok_at(0, iv(3, 'h9100, 'h8, 0)), 'h8fff, 'h9007, 0, 0, 0, 1, 'h1210,
		        'h1220, out);
		it = mk(fwd_ext_pkg::F_RUN, fwd_ext_pkg::BASE_T, 1, 'h200, 'h4, 2, 60, 10);
		out = it;
		out.status = fwd_ext_pkg::F_BREAK;
		set_vec(5, it, ok_at(0, iv(0, 'h300, 'h4, 0)), 'h1ff, 'h203, 0, 0, 0, 0, 0, 0, out);
		it = mk(fwd_ext_pkg::F_RUN, fwd_ext_pkg::BASE_N, 9, 'h40, 'h10, 5, 70, 10);
		out = it;
		out.status = fwd_ext_pkg::F_BREAK;
		out.ptr_curr = 10;
		set_vec(6, it, ok_at(0, iv(0, 0, 0, 0)), 'h3f, 'h4f, 1, 0, 0, 0, 0, 0, out);
		it = mk(fwd_ext_pkg::F_BREAK, fwd_ext_pkg::BASE_A, 4, 'h30, 'h2, 'h1_0000_0065, 101, 10);
		out = it;
		out.status = fwd_ext_pkg::BCK_INI;
		out.ptr_curr = 5;
		set_vec(7, it, '0, 'h2f, 'h31, 1, 1, 'h65, 0, 0, 0, out);
		it = mk(fwd_ext_pkg::F_BREAK, fwd_ext_pkg::BASE_C, 3, 'h30, 'h2, 'h12345678_9abcdef0, 50,
		        10);
		out = it;
		out.status = fwd_ext_pkg::BCK_INI;
		set_vec(8, it, '0, 'h2f, 'h31, 0, 1, 'h9abcdef0, 0, 0, 0, out);
		it = mk(fwd_ext_pkg::F_RUN, fwd_ext_pkg::BASE_A, 6, 'h80, 'h20, 'h64, 101, 10);
		out = it;
		out.status = fwd_ext_pkg::BCK_INI;  // limit hit in the first stage
		out.ptr_curr = 7;
		set_vec(9, it, '0, 'h7f, 'h9f, 1, 1, 'h64, 0, 0, 0, out);
		it = mk(fwd_ext_pkg::F_RUN, fwd_ext_pkg::BASE_G, 2, 'h80, 'h20, 'h77, 120, 10);
		out = it;
		out.status = fwd_ext_pkg::BCK_INI;
		set_vec(10, it, '0, 'h7f, 'h9f, 0, 1, 'h77, 0, 0, 0, out);
		it = mk(fwd_ext_pkg::BCK_INI, fwd_ext_pkg::BASE_T, 1, 'h50, 'h3, 0, 10, 10);
		set_vec(11, it, '0, 'h4f, 'h52, 0, 0, 0, 0, 0, 0, it);
	endtask

	function automatic int pending();
		return curr_q.size() + ret_q.size() + mem_q.size() + item_q.size();
	endfunction

	// ------------------------------------------------------------------
	// stall source, occurrence unit model and checker
	// ------------------------------------------------------------------
	always @(posedge Clk_32UI) begin : stall_gen
		logic [31:0] s1;
		logic [31:0] s2;
		s1 = lfsr_step(lfsr);
		s2 = lfsr_step(s1);
		if (run_en) begin
			lfsr    <= s2;
			stall_i <= s1[0] & s2[0];  // about one cycle in four
		end else begin
			stall_i <= 1'b0;
		end
	end

	always @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			for (int i = 0; i <= D; i++) occ_idx[i] <= -1;
			ok_i <= '0;
		end else if (!stall_i) begin
			occ_idx[0] <= drv_idx;
			for (int i = 1; i <= D; i++) occ_idx[i] <= occ_idx[i-1];
			ok_i <= (occ_idx[D-1] >= 0) ? vec_tbl[occ_idx[D-1]].ok : '0;  // results due next cycle
		end
	end

	always @(negedge Clk_32UI) begin
		if (check_en && !stall_i) begin
			if (occ_idx[0] >= 0) check_occ(occ_req_o, vec_tbl[occ_idx[0]].occ);
			if (curr_wr_o.we) begin
				if (curr_q.size() == 0) abort_run("queue write that no item expects");
				else check_curr(curr_wr_o, curr_q.pop_front());
			end
			if (ret_o.valid) begin
				if (ret_q.size() == 0) abort_run("return pulse that no item expects");
				else check_ret(ret_o, ret_q.pop_front());
			end
			if (mem_req_o.valid) begin
				if (mem_q.size() == 0) abort_run("dram request that no item expects");
				else check_mem(mem_req_o, mem_q.pop_front());
			end else begin
				check_mem(mem_req_o, '0);  // no request, both addresses zero
			end
			if (item_o.status != fwd_ext_pkg::BUBBLE) begin
				if (item_q.size() == 0) abort_run("output item that no input matches");
				else check_item(item_o, item_q.pop_front());
			end
		end
	end

	initial begin
		bubble           = '0;
		bubble.status    = fwd_ext_pkg::BUBBLE;
		reset_BWT_extend = 1'b0;
		stall_i          = 1'b0;
		primary_i        = 64'h10000;
		item_i           = bubble;
		ok_i             = '0;
		drv_idx          = -1;
		lfsr             = 32'h97772059;
		run_en           = 1'b0;
		check_en         = 1'b0;
		build_table();
		for (int i = 0; i < NVEC; i++) begin
			if (vec_tbl[i].curr.we) curr_q.push_back(vec_tbl[i].curr);
			if (vec_tbl[i].ret.valid) ret_q.push_back(vec_tbl[i].ret);
			if (vec_tbl[i].mem.valid) mem_q.push_back(vec_tbl[i].mem);
			item_q.push_back(vec_tbl[i].out);
		end

		repeat (10) @(posedge Clk_32UI);
		reset_BWT_extend <= 1'b1;
		repeat (3) begin
			@(negedge Clk_32UI);
			if (curr_wr_o.we !== 1'b0 || ret_o.valid !== 1'b0 || mem_req_o.valid !== 1'b0 ||
			    item_o.status !== fwd_ext_pkg::BUBBLE) begin
				abort_run("outputs are not idle after reset");
			end
		end
		@(posedge Clk_32UI);
		run_en   <= 1'b1;
		check_en <= 1'b1;

		// one table entry per cycle in which the DUT takes its input
		idx      = 0;
		wait_cnt = 0;
		while (idx <= NVEC) begin
			@(posedge Clk_32UI);
			if (!stall_i) begin
				item_i  <= (idx < NVEC) ? vec_tbl[idx].item : bubble;
				drv_idx <= (idx < NVEC) ? idx : -1;
				idx++;
				wait_cnt = 0;
			end else begin
				wait_cnt++;
				if (wait_cnt > TIMEOUT) abort_run("input held back by stall for too long");
			end
		end

		wait_cnt = 0;
		while (pending() != 0 && wait_cnt < TIMEOUT) begin
			@(posedge Clk_32UI);
			wait_cnt++;
		end
		repeat (30) @(posedge Clk_32UI);  // catch late extra strobes
		if (pending() == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			abort_run("timeout while waiting for expected results");
		end
	end

endmodule

//--- filelist.f
+incdir+verification
rtl/fwd_ext_pkg.sv
rtl/occ_position_stage.sv
rtl/item_delay_line.sv
rtl/extend_decision.sv
rtl/interval_update.sv
rtl/dram_request_stage.sv
rtl/forward_extend_top.sv
verification/tb_forward_extend.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module tb_forward_extend -f filelist.f -o sim_forward_extend
./obj_dir/sim_forward_extend > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
	exit 1
fi
grep -q "Test passed" sim.log
